/* compile.f */
codec_pkg.sv
dma_pkg.sv
codec_stream_if.sv
codein.sv
code_enc.sv
code_dec.sv
codeout.sv
codec_top.sv
tb_codec_top.sv

/* Makefile */
# Verilator build and run for the codec engine testbench

VERILATOR ?= verilator
TOP       ?= tb_codec_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_codec_top.sv */
/*
   Directed testbench for codec_top with CREDITS of 4.
   Expected words come from a chained-XOR model of the cipher and the byte swap.
   Inputs change 1 time unit after the rising edge, outputs are sampled on the falling edge.
*/
module tb_codec_top
   import codec_pkg::*;
();

   localparam int TOTAL_WORDS     = 33;   // words offered over all tests
   localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 400;

   logic            wb_clk_i;
   logic            wb_rst_i;
   logic [DC_W-1:0] dc_i;
   logic            m_enable_i;
   logic [63:0]     m_src_i;
   logic            m_src_valid_i;
   logic            m_src_last_i;
   logic            m_credit_i;
   logic            m_src_take_o;
   logic [63:0]     m_dst_o;
   logic            m_dst_putn_o;
   logic            m_dst_last_o;
   logic            m_endn_o;

   integer      seed;
   int          errors;
   int          test_errs;
   int          tests_run;
   int          tests_failed;
   int          take_count;
   int          credit_pend;   // credit pulses still to be returned
   bit          auto_credit;
   string       test_name;
   logic [63:0] plain_q[$];
   logic [63:0] cipher_q[$];   // model output before the byte swap
   logic [63:0] src_q[$];
   logic [63:0] exp_q[$];
   logic [63:0] got_q[$];
   logic        last_seen_q[$];
   logic        endn_seen_q[$];

   codec_top #(.CREDITS(4)) codec_top_inst (.*);

   always #50 wb_clk_i = ~wb_clk_i;

   // sink: one entry per putn pulse, and a credit back for each word when enabled
   always @(negedge wb_clk_i)
   begin
      if (!wb_rst_i && !m_dst_putn_o)
      begin
         got_q.push_back(m_dst_o);
         last_seen_q.push_back(m_dst_last_o);
         endn_seen_q.push_back(m_endn_o);
         if (auto_credit)
            credit_pend++;
      end
      if (m_src_valid_i && m_src_take_o)
         take_count++;
   end

   always @(posedge wb_clk_i)
   begin
      #1;
      m_credit_i = credit_pend > 0;   // one credit per cycle
      if (credit_pend > 0)
         credit_pend--;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge wb_clk_i);
      $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

   task automatic check(input logic [63:0] expected, input logic [63:0] actual);
      if (expected !== actual)
      begin
         $display("mismatch in %s: expected %h, actual %h", test_name, expected, actual);
         errors++;
         test_errs++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("error in %s: %s", test_name, msg);
      errors++;
      test_errs++;
   endtask

   function automatic logic [63:0] swap_bytes(input logic [63:0] w);
      logic [63:0] s;
      for (int i = 0; i < 4; i++)
         s[i*16 +: 16] = {w[i*16 +: 8], w[i*16+8 +: 8]};
      return s;
   endfunction

   task automatic make_plain(input int n);
      plain_q.delete();
      repeat (n) plain_q.push_back({$random(seed), $random(seed)});
   endtask

   // chain value is the previous cipher lane, zero at the start of a job
   task automatic encode_model(input logic [15:0] key);
      logic [15:0] prev;
      logic [63:0] c;
      prev = '0;
      cipher_q.delete();
      foreach (plain_q[w])
      begin
         for (int i = 0; i < 4; i++)
         begin
            c[i*16 +: 16] = plain_q[w][i*16 +: 16] ^ (key + prev);
            prev = c[i*16 +: 16];
         end
         cipher_q.push_back(c);
      end
   endtask

   task automatic expect_cipher(input int n);
      exp_q.delete();
      for (int i = 0; i < n; i++)
         exp_q.push_back(swap_bytes(cipher_q[i]));
   endtask

   task automatic clear_sink();
      got_q.delete();
      last_seen_q.delete();
      endn_seen_q.delete();
   endtask

   task automatic start_test(input string name, input logic [DC_W-1:0] dc);
      test_name = name;
      test_errs = 0;
      take_count = 0;
      clear_sink();
      dc_i = dc;
      m_enable_i = 1'b1;
   endtask

   task automatic end_test();
      m_enable_i = 1'b0;
      while (credit_pend > 0)
         @(posedge wb_clk_i);
      repeat (2) @(posedge wb_clk_i);
      #1;
      tests_run++;
      if (test_errs != 0)
         tests_failed++;
      $display("test %s: %s (%0d errors)", test_name, test_errs == 0 ? "ok" : "failed",
               test_errs);
   endtask

   // holds one word on the source port until it is taken or max_cycles pass
   task automatic offer_word(input logic [63:0] w, input logic last, input int max_cycles,
                             output logic taken);
      int n;
      n = 0;
      taken = 1'b0;
      m_src_i = w;
      m_src_valid_i = 1'b1;
      m_src_last_i = last;
      while (!taken && n < max_cycles)
      begin
         @(negedge wb_clk_i);
         taken = m_src_take_o;
         n++;
      end
      @(posedge wb_clk_i);
      #1;
      m_src_valid_i = 1'b0;
      m_src_last_i = 1'b0;
   endtask

   task automatic send_src();
      logic taken;
      for (int i = 0; i < src_q.size(); i++)
      begin
         offer_word(src_q[i], i == src_q.size() - 1, 40, taken);
         if (!taken)
            report_error("a source word was never taken");
      end
   endtask

   task automatic wait_words(input int n);
      int cycles;
      cycles = 0;
      while (got_q.size() < n && cycles < 200)
      begin
         @(negedge wb_clk_i);
         cycles++;
      end
      if (got_q.size() < n)
         report_error("destination words stopped arriving");
      repeat (8) @(negedge wb_clk_i);
      @(posedge wb_clk_i);
      #1;
      check(64'(n), 64'(got_q.size()));   // no extra putn pulses either
   endtask

   task automatic compare_words();
      check(64'(exp_q.size()), 64'(got_q.size()));
      for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
         check(exp_q[i], got_q[i]);
   endtask

   task automatic test_encode();
      make_plain(8);
      encode_model(16'ha5c3);
      start_test("encode", {16'ha5c3, 8'h20});
      src_q = plain_q;
      send_src();
      wait_words(8);
      expect_cipher(8);
      compare_words();
      end_test();
   endtask

   // feeds the unswapped cipher of the encode test back, expecting the plaintext
   task automatic test_decode();
      start_test("decode", {16'ha5c3, 8'h40});
      src_q = cipher_q;
      exp_q = plain_q;
      send_src();
      wait_words(8);
      compare_words();
      end_test();
   endtask

   task automatic test_credit_stall();
      logic taken;
      make_plain(7);
      encode_model(16'h5a3c);
      start_test("credit_stall", {16'h5a3c, 8'h20});
      auto_credit = 1'b0;
      for (int i = 0; i < 4; i++)
      begin
         offer_word(plain_q[i], 1'b0, 20, taken);
         if (!taken)
            report_error("a word was refused while credits were left");
      end
      offer_word(plain_q[4], 1'b0, 30, taken);
      if (taken)
         report_error("a word was taken with no credits left");
      check(64'd4, 64'(take_count));
      wait_words(4);
      credit_pend += 2;
      offer_word(plain_q[4], 1'b0, 20, taken);
      if (!taken)
         report_error("the first returned credit was not used");
      offer_word(plain_q[5], 1'b1, 20, taken);
      if (!taken)
         report_error("the second returned credit was not used");
      offer_word(plain_q[6], 1'b0, 30, taken);
      if (taken)
         report_error("more words were taken than credits returned");
      check(64'd6, 64'(take_count));
      wait_words(6);
      expect_cipher(6);
      compare_words();
      credit_pend += 4;   // refill the counter to its ceiling
      auto_credit = 1'b1;
      end_test();
   endtask

   task automatic test_last_end();
      make_plain(3);
      encode_model(16'h0f1e);
      start_test("last_end", {16'h0f1e, 8'h20});
      src_q = plain_q;
      send_src();
      wait_words(3);
      expect_cipher(3);
      compare_words();
      for (int i = 0; i < last_seen_q.size(); i++)
      begin
         check(64'(i == 2), 64'(last_seen_q[i]));
         check(64'd1, 64'(endn_seen_q[i]));
      end
      check(64'd1, 64'(m_dst_last_o));
      check(64'd0, 64'(m_endn_o));
      m_enable_i = 1'b0;
      @(posedge wb_clk_i);
      #1;
      check(64'd0, 64'(m_dst_last_o));
      check(64'd1, 64'(m_endn_o));
      // second job with both mode bits set, so encode wins
      make_plain(2);
      encode_model(16'h1234);
      clear_sink();
      dc_i = {16'h1234, 8'h60};
      m_enable_i = 1'b1;
      src_q = plain_q;
      send_src();
      wait_words(2);
      expect_cipher(2);
      compare_words();
      if (last_seen_q.size() == 2)
      begin
         check(64'd0, 64'(last_seen_q[0]));
         check(64'd1, 64'(last_seen_q[1]));
      end
      end_test();
   endtask

   task automatic test_idle();
      logic taken;
      make_plain(5);
      start_test("idle_mode", {16'h7777, 8'h00});
      for (int i = 0; i < 4; i++)
      begin
         offer_word(plain_q[i], i == 3, 20, taken);
         if (!taken)
            report_error("idle mode refused a word while credits were left");
      end
      offer_word(plain_q[4], 1'b0, 30, taken);
      if (taken)
         report_error("idle mode took a word with no credits left");
      // the job has ended inside the DUT, yet last and end stay gated off
      repeat (10)
      begin
         @(negedge wb_clk_i);
         check(64'd0, m_dst_o);
         check(64'd1, 64'(m_dst_putn_o));
         check(64'd0, 64'(m_dst_last_o));
         check(64'd1, 64'(m_endn_o));
      end
      @(posedge wb_clk_i);
      #1;
      check(64'd0, 64'(got_q.size()));
      end_test();
   endtask

   initial
   begin
      seed = 32'hb4e5;
      wb_clk_i = 1'b0;
      wb_rst_i = 1'b1;
      dc_i = '0;
      m_enable_i = 1'b0;
      m_src_i = '0;
      m_src_valid_i = 1'b0;
      m_src_last_i = 1'b0;
      m_credit_i = 1'b0;
      credit_pend = 0;
      auto_credit = 1'b1;
      repeat (2) @(posedge wb_clk_i);
      #1;
      wb_rst_i = 1'b0;
      test_encode();
      test_decode();
      test_credit_stall();
      test_last_end();
      test_idle();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* codec_top.sv */
/*
   Top level of the DMA codec engine data path.
   The sink returns one m_credit_i pulse per destination word it can take.
   CREDITS sets both the starting credit count and its ceiling, 1..15.
*/
module codec_top
   import codec_pkg::*;
   import dma_pkg::*;
#(
   parameter int CREDITS = 4
)
(
   input  logic              wb_clk_i,
   input  logic              wb_rst_i,
   input  logic [DC_W-1:0]   dc_i,
   input  logic              m_enable_i,
   input  logic [WORD_W-1:0] m_src_i,
   input  logic              m_src_valid_i,
   input  logic              m_src_last_i,
   input  logic              m_credit_i,
   output logic              m_src_take_o,
   output logic [WORD_W-1:0] m_dst_o,
   output logic              m_dst_putn_o,
   output logic              m_dst_last_o,
   output logic              m_endn_o
);

   codec_mode_e       mode;
   logic [LANE_W-1:0] key;

   assign mode = dc_mode(dc_i);
   assign key  = dc_i[DC_KEY_LSB +: LANE_W];

   codec_stream_if lane_s ();   // source lanes, read by both cores
   codec_stream_if enc_s ();
   codec_stream_if dec_s ();

   codein #(
      .CREDITS (CREDITS)
   ) codein_inst (
      .wb_clk_i      (wb_clk_i),
      .wb_rst_i      (wb_rst_i),
      .m_enable_i    (m_enable_i),
      .m_src_i       (m_src_i),
      .m_src_valid_i (m_src_valid_i),
      .m_src_last_i  (m_src_last_i),
      .m_credit_i    (m_credit_i),
      .m_src_take_o  (m_src_take_o),
      .lane_o        (lane_s)
   );

   code_enc code_enc_inst (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .key_i    (key),
      .in_s     (lane_s),
      .out_s    (enc_s)
   );

   code_dec code_dec_inst (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .key_i    (key),
      .in_s     (lane_s),
      .out_s    (dec_s)
   );

   codeout codeout_inst (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .mode_i       (mode),
      .m_enable_i   (m_enable_i),
      .enc_i        (enc_s),
      .dec_i        (dec_s),
      .m_dst_o      (m_dst_o),
      .m_dst_putn_o (m_dst_putn_o),
      .m_dst_last_o (m_dst_last_o),
      .m_endn_o     (m_endn_o)
   );

endmodule

/* codeout.sv */
/*
   Destination side of the codec engine.
   Encoded lanes are byte-swapped on the way out. Four lanes, low first, make one word
   and m_dst_putn_o pulses low for one cycle per word.
   All outputs read inactive while disabled or in idle mode.
*/
module codeout
   import codec_pkg::*;
   import dma_pkg::*;
(
   input  logic              wb_clk_i,
   input  logic              wb_rst_i,
   input  codec_mode_e       mode_i,
   input  logic              m_enable_i,
   codec_stream_if.snk       enc_i,
   codec_stream_if.snk       dec_i,
   output logic [WORD_W-1:0] m_dst_o,
   output logic              m_dst_putn_o,
   output logic              m_dst_last_o,
   output logic              m_endn_o
);

   localparam logic [1:0] LAST_LANE = 2'(LANES - 1);

   logic [LANE_W-1:0] lane_data;
   logic              lane_valid;
   logic              lane_first;
   logic              lane_done;
   logic [1:0]        lane_q;
   logic [1:0]        idx;
   logic [WORD_W-1:0] dst_q;
   logic              putn_q;
   out_seq_e          seq_q;
   logic              sel;

   always_comb
   begin
      if (mode_i == MODE_ENC)
      begin
         lane_data  = {enc_i.data[7:0], enc_i.data[15:8]};   // byte swap
         lane_valid = enc_i.valid;
         lane_first = enc_i.first;
         lane_done  = enc_i.done;
      end
      else
      begin
         lane_data  = dec_i.data;
         lane_valid = dec_i.valid;
         lane_first = dec_i.first;
         lane_done  = dec_i.done;
      end
   end

   // a first lane always lands at the bottom of the word
   assign idx = lane_first ? 2'd0 : lane_q;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         lane_q <= '0;
      else if (!m_enable_i)
         lane_q <= '0;
      else if (lane_valid)
         lane_q <= idx + 1'b1;
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (lane_valid)
         dst_q[idx*LANE_W +: LANE_W] <= lane_data;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         putn_q <= 1'b1;
      else
         putn_q <= !(lane_valid && idx == LAST_LANE);
   end

   // last rises with the final putn pulse, end follows one cycle later
   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         seq_q <= SEQ_RUN;
      else if (!m_enable_i)
         seq_q <= SEQ_RUN;
      else
         case (seq_q)
            SEQ_RUN:  if (lane_valid && lane_done) seq_q <= SEQ_LAST;
            SEQ_LAST: seq_q <= SEQ_END;
            default:  seq_q <= SEQ_END;
         endcase
   end

   assign sel = m_enable_i && mode_i != MODE_IDLE;

   assign m_dst_o      = sel ? dst_q : '0;
   assign m_dst_putn_o = sel ? putn_q : 1'b1;
   assign m_dst_last_o = sel && seq_q != SEQ_RUN;
   assign m_endn_o     = sel ? seq_q != SEQ_END : 1'b1;

endmodule

/* code_dec.sv */
/*
   Chained-XOR decoder with one register stage.
   out = in ^ (key + previous in), which undoes code_enc for the same key.
   The chain restarts from zero on a lane flagged first.
*/
module code_dec
   import codec_pkg::*;
(
   input  logic              wb_clk_i,
   input  logic              wb_rst_i,
   input  logic [LANE_W-1:0] key_i,
   codec_stream_if.snk       in_s,
   codec_stream_if.src       out_s
);

   logic [LANE_W-1:0] chain;
   logic [LANE_W-1:0] prev_q;   // previous cipher lane seen at the input
   logic [LANE_W-1:0] data_q;
   logic              valid_q;
   logic              first_q;
   logic              done_q;

   assign chain = in_s.first ? '0 : prev_q;

   always_ff @(posedge wb_clk_i)
   begin
      if (in_s.valid)
      begin
         prev_q <= in_s.data;
         data_q <= in_s.data ^ (key_i + chain);
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         valid_q <= 1'b0;
         first_q <= 1'b0;
         done_q  <= 1'b0;
      end
      else
      begin
         valid_q <= in_s.valid;
         first_q <= in_s.valid && in_s.first;
         done_q  <= in_s.valid && in_s.done;
      end
   end

   assign out_s.data  = data_q;
   assign out_s.valid = valid_q;
   assign out_s.first = first_q;
   assign out_s.done  = done_q;

endmodule

/* code_enc.sv */
/*
   Chained-XOR encoder with one register stage.
   out = in ^ (key + previous out), the sum taken modulo 2^16.
   The chain restarts from zero on a lane flagged first.
*/
module code_enc
   import codec_pkg::*;
(
   input  logic              wb_clk_i,
   input  logic              wb_rst_i,
   input  logic [LANE_W-1:0] key_i,
   codec_stream_if.snk       in_s,
   codec_stream_if.src       out_s
);

   logic [LANE_W-1:0] chain;
   logic [LANE_W-1:0] data_q;   // last encoded lane, also the chain value
   logic              valid_q;
   logic              first_q;
   logic              done_q;

   assign chain = in_s.first ? '0 : data_q;

   always_ff @(posedge wb_clk_i)
   begin
      if (in_s.valid)
         data_q <= in_s.data ^ (key_i + chain);
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         valid_q <= 1'b0;
         first_q <= 1'b0;
         done_q  <= 1'b0;
      end
      else
      begin
         valid_q <= in_s.valid;
         first_q <= in_s.valid && in_s.first;
         done_q  <= in_s.valid && in_s.done;
      end
   end

   assign out_s.data  = data_q;
   assign out_s.valid = valid_q;
   assign out_s.first = first_q;
   assign out_s.done  = done_q;

endmodule

/* codein.sv */
/*
   Source side of the codec engine.
   A word is taken only while a credit is held. One credit is spent per word and
   the count never rises above CREDITS, which must lie in 1..15.
   Lanes leave low lane first, one per cycle, starting the cycle after the take.
*/
module codein
   import codec_pkg::*;
   import dma_pkg::*;
#(
   parameter int CREDITS = 4
)
(
   input  logic              wb_clk_i,
   input  logic              wb_rst_i,
   input  logic              m_enable_i,
   input  logic [WORD_W-1:0] m_src_i,
   input  logic              m_src_valid_i,
   input  logic              m_src_last_i,
   input  logic              m_credit_i,
   output logic              m_src_take_o,
   codec_stream_if.src       lane_o
);

   localparam logic [1:0] LAST_LANE = 2'(LANES - 1);

   logic [CREDIT_W-1:0] credit_q;
   logic [WORD_W-1:0]   word_q;
   logic [1:0]          lane_q;
   logic                busy_q;
   logic                first_q;   // next lane 0 opens a job
   logic                last_q;    // word in flight closes the job
   logic                take;

   // a new word may land while lane 3 of the previous one goes out
   assign take = m_enable_i && (credit_q != '0) && m_src_valid_i &&
                 (!busy_q || lane_q == LAST_LANE);
   assign m_src_take_o = take;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         credit_q <= CREDIT_W'(CREDITS);
      else if (take && !m_credit_i)
         credit_q <= credit_q - 1'b1;
      else if (m_credit_i && !take && credit_q < CREDIT_W'(CREDITS))
         credit_q <= credit_q + 1'b1;   // saturates at the ceiling
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         busy_q <= 1'b0;
         lane_q <= '0;
         last_q <= 1'b0;
      end
      else if (take)
      begin
         busy_q <= 1'b1;
         lane_q <= '0;
         last_q <= m_src_last_i;
      end
      else if (busy_q)
      begin
         lane_q <= lane_q + 1'b1;
         if (lane_q == LAST_LANE)
            busy_q <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         first_q <= 1'b1;
      else if (!m_enable_i)
         first_q <= 1'b1;   // rearm for the next job
      else if (busy_q && lane_q == '0)
         first_q <= 1'b0;
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (take)
         word_q <= m_src_i;
   end

   assign lane_o.data  = word_q[lane_q*LANE_W +: LANE_W];
   assign lane_o.valid = busy_q;
   assign lane_o.first = busy_q && lane_q == '0 && first_q;
   assign lane_o.done  = busy_q && lane_q == LAST_LANE && last_q;

endmodule

/* codec_stream_if.sv */
/*
   One 16-bit lane stream between the packer stages.
   There is no back-pressure, so the receiver must take every valid lane.
*/
interface codec_stream_if import codec_pkg::*; ();

   logic [LANE_W-1:0] data;
   logic              valid;
   logic              first;   // lane 0 of the first word of a job
   logic              done;    // lane 3 of the last word of a job

   modport src (output data, output valid, output first, output done);
   modport snk (input data, input valid, input first, input done);

endinterface

/* dma_pkg.sv */
/*
   Host-side definitions for the DMA codec engine.
   Jobs move whole 64-bit words only, so no partial-word flush exists.
*/
package dma_pkg;

   localparam int WORD_W   = 64;   // source and destination word
   localparam int LANES    = 4;    // lanes of LANE_W bits per word
   localparam int CREDIT_W = 4;    // holds up to 15 credits

   // end-of-job sequence on the destination side
   typedef enum logic [1:0]
   {
      SEQ_RUN  = 2'd0,
      SEQ_LAST = 2'd1,
      SEQ_END  = 2'd2
   } out_seq_e;

endpackage

/* codec_pkg.sv */
/*
   Codec-side definitions for the DMA codec engine.
   The descriptor control word carries the encode and decode mode bits and a 16-bit key.
   If both mode bits are set, encode wins.
*/
package codec_pkg;

   localparam int LANE_W     = 16;   // one codec lane
   localparam int DC_W       = 24;   // descriptor control word
   localparam int DC_ENC_BIT = 5;
   localparam int DC_DEC_BIT = 6;
   localparam int DC_KEY_LSB = 8;    // key occupies dc[23:8]

   typedef enum logic [1:0]
   {
      MODE_IDLE = 2'd0,
      MODE_ENC  = 2'd1,
      MODE_DEC  = 2'd2
   } codec_mode_e;

   // encode has priority when both bits are set
   function automatic codec_mode_e dc_mode(input logic [DC_W-1:0] dc);
      codec_mode_e mode;
      if (dc[DC_ENC_BIT])
         mode = MODE_ENC;
      else if (dc[DC_DEC_BIT])
         mode = MODE_DEC;
      else
         mode = MODE_IDLE;
      return mode;
   endfunction

endpackage
